/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = stim_source_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
+incdir+src
src/rec_pkg.sv
src/beat_pkg.sv
src/rec_sequencer.sv
src/rec_store.sv
src/align_delay.sv
src/frame_stream_gen.sv
src/stim_source_top.sv
test/stim_source_props.sv
test/stim_source_tb.sv

/* src/align_delay.sv */
`timescale 1ns/1ns

module align_delay #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  T     d_i,
  output T     d_o
);

  generate
    if (DEPTH == 0) begin : g_pass
      // no stages
      assign d_o = d_i;
    end else begin : g_chain
      T stage [DEPTH];

      // shift chain, stage 0 takes the input
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < DEPTH; i++) begin
            stage[i] <= '0;
          end
        end else begin
          stage[0] <= d_i;
          for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
          end
        end
      end

      assign d_o = stage[DEPTH-1];
    end
  endgenerate

endmodule

/* src/beat_pkg.sv */
`include "stim_defines.svh"

package beat_pkg;

  ////////////////////////////////////////
  // stream beat
  ////////////////////////////////////////

  // payload of one beat without its valid
  typedef struct packed {
    logic [`BEAT_WIDTH-1:0] data;
    // end of row
    logic                   last;
  } beat_t;

endpackage

/* src/frame_stream_gen.sv */
`timescale 1ns/1ns
`include "stim_defines.svh"

module frame_stream_gen (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            ready_i,
  output beat_pkg::beat_t beat_o,
  output logic            valid_o
);

  localparam int COL_W = (`ROW_COLS > 1) ? $clog2(`ROW_COLS) : 1;
  localparam int ROW_W = (`FRAME_ROWS > 1) ? $clog2(`FRAME_ROWS) : 1;
  localparam int GAP_W = (`ROW_GAP > 1) ? $clog2(`ROW_GAP) : 1;
  // gap counter start, counts down to zero while valid is low
  localparam int GAP_LOAD = (`ROW_GAP > 0) ? `ROW_GAP - 1 : 0;

  logic [COL_W-1:0]       col_cnt;
  logic [ROW_W-1:0]       row_cnt;
  logic [GAP_W-1:0]       gap_cnt;
  logic [`BEAT_WIDTH-1:0] data_cnt;
  logic                   fire;
  logic                   row_end;
  logic                   frame_end;

  assign fire      = valid_o & ready_i;
  assign row_end   = (col_cnt == COL_W'(`ROW_COLS - 1));
  assign frame_end = row_end && (row_cnt == ROW_W'(`FRAME_ROWS - 1));

  ////////////////////////////////////////
  // position in the frame
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (fire) begin
      if (row_end) begin
        col_cnt <= '0;
        if (frame_end) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // beat data, wraps at the end of each frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_cnt <= '0;
    end else if (fire) begin
      if (frame_end) begin
        data_cnt <= '0;
      end else begin
        data_cnt <= data_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // valid and row gap
  ////////////////////////////////////////

  // valid drops after a row, rises once the gap has run out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      gap_cnt <= '0;
    end else if (fire && row_end) begin
      valid_o <= (`ROW_GAP == 0);
      gap_cnt <= GAP_W'(GAP_LOAD);
    end else if (!valid_o) begin
      if (gap_cnt == '0) begin
        valid_o <= 1'b1;
      end else begin
        gap_cnt <= gap_cnt - 1'b1;
      end
    end
  end

  // counters only move on a transfer, so the beat holds under back-pressure
  assign beat_o.data = data_cnt;
  assign beat_o.last = row_end;

endmodule

/* src/rec_pkg.sv */
`include "stim_defines.svh"

package rec_pkg;

  ////////////////////////////////////////
  // record words
  ////////////////////////////////////////

  typedef logic [`REC_ADDR_WIDTH-1:0] rec_addr_t;

  typedef logic [`REC_WIDTH-1:0] rec_data_t;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // write into the record store
  typedef struct packed {
    logic      en;
    rec_addr_t addr;
    rec_data_t data;
  } rec_load_t;

  // read request, also the tag that travels with the data
  typedef struct packed {
    logic      valid;
    rec_addr_t addr;
  } rec_tag_t;

endpackage

/* src/rec_sequencer.sv */
`timescale 1ns/1ns
`include "stim_defines.svh"

module rec_sequencer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rd_en_i,
  output rec_pkg::rec_tag_t req_o
);

  localparam int PASS_W = $clog2(`REC_PASSES + 1);

  rec_pkg::rec_addr_t next_addr;
  logic [PASS_W-1:0]  pass_cnt;
  logic               passes_done;
  logic               issue;
  logic               addr_wrap;

  ////////////////////////////////////////
  // request issue
  ////////////////////////////////////////

  assign passes_done = (pass_cnt == PASS_W'(`REC_PASSES));
  assign issue       = rd_en_i & ~passes_done;
  assign addr_wrap   = (next_addr == `REC_ADDR_WIDTH'(`REC_DEPTH - 1));

  // next address to hand out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr <= '0;
    end else if (issue) begin
      if (addr_wrap) begin
        next_addr <= '0;
      end else begin
        next_addr <= next_addr + 1'b1;
      end
    end
  end

  // one pass per wrap, stops counting at the limit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_cnt <= '0;
    end else if (issue && addr_wrap) begin
      pass_cnt <= pass_cnt + 1'b1;
    end
  end

  // registered request toward the store
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_o <= '0;
    end else begin
      req_o.valid <= issue;
      if (issue) begin
        req_o.addr <= next_addr;
      end
    end
  end

endmodule

/* src/rec_store.sv */
`timescale 1ns/1ns
`include "stim_defines.svh"

module rec_store (
  input  logic               clk,
  input  logic               rst_n,
  input  rec_pkg::rec_load_t load_i,
  input  rec_pkg::rec_tag_t  req_i,
  output rec_pkg::rec_tag_t  tag_o,
  output rec_pkg::rec_data_t data_o
);

  rec_pkg::rec_data_t mem [`REC_DEPTH];

  ////////////////////////////////////////
  // memory
  ////////////////////////////////////////

  // load port
  always_ff @(posedge clk) begin
    if (load_i.en) begin
      mem[load_i.addr] <= load_i.data;
    end
  end

  // registered read, address is always in range
  always_ff @(posedge clk) begin
    data_o <= mem[req_i.addr];
  end

  ////////////////////////////////////////
  // tag
  ////////////////////////////////////////

  // tag follows the data by the same one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_o <= '0;
    end else begin
      tag_o <= req_i;
    end
  end

endmodule

/* src/stim_defines.svh */
`ifndef STIM_DEFINES_SVH
`define STIM_DEFINES_SVH

////////////////////////////////////////
// record path
////////////////////////////////////////

// width of one record word
`define REC_WIDTH       32
// records held in the store
`define REC_DEPTH       16
`define REC_ADDR_WIDTH  4
// full passes over the store before reads stop
`define REC_PASSES      3
// extra register stages after the store
`define REC_OUT_DELAY   2

////////////////////////////////////////
// stream path
////////////////////////////////////////

`define BEAT_WIDTH      8
// beats per row, tlast on the final one
`define ROW_COLS        8
`define FRAME_ROWS      4
// idle cycles between rows
`define ROW_GAP         4

`endif

/* src/stim_source_top.sv */
`timescale 1ns/1ns
`include "stim_defines.svh"

module stim_source_top (
  input  logic               clk,
  input  logic               rst_n,
  input  rec_pkg::rec_load_t load_i,
  input  logic               rd_en_i,
  input  logic               beat_ready_i,
  output rec_pkg::rec_tag_t  rec_tag_o,
  output rec_pkg::rec_data_t rec_data_o,
  output beat_pkg::beat_t    beat_o,
  output logic               beat_valid_o
);

  rec_pkg::rec_tag_t  req;
  rec_pkg::rec_tag_t  tag;
  rec_pkg::rec_data_t data;

  ////////////////////////////////////////
  // record path
  ////////////////////////////////////////

  rec_sequencer u_rec_sequencer (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_en_i (rd_en_i),
    .req_o   (req)
  );

  rec_store u_rec_store (
    .clk    (clk),
    .rst_n  (rst_n),
    .load_i (load_i),
    .req_i  (req),
    .tag_o  (tag),
    .data_o (data)
  );

  // same depth on both so tag and data stay aligned
  align_delay #(
    .T     (rec_pkg::rec_tag_t),
    .DEPTH (`REC_OUT_DELAY)
  ) u_tag_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (tag),
    .d_o   (rec_tag_o)
  );

  align_delay #(
    .T     (rec_pkg::rec_data_t),
    .DEPTH (`REC_OUT_DELAY)
  ) u_data_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (data),
    .d_o   (rec_data_o)
  );

  ////////////////////////////////////////
  // stream path
  ////////////////////////////////////////

  frame_stream_gen u_frame_stream_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready_i (beat_ready_i),
    .beat_o  (beat_o),
    .valid_o (beat_valid_o)
  );

endmodule

/* test/stim_golden.txt */
// record image, one 32-bit hex word per address 0 to 15
// final word: accepted beats per frame before the data wraps
3c5a9e01
b7e21f42
0d94c6a3
e1387b54
5a0fd215
92c4e876
47bd03a7
f8163c98
21e95b49
cc702e1a
6b4af8db
083d91ec
d5e6a47d
7f21c30e
a9583dff
14c76b20
00000020

/* test/stim_source_props.sv */
`timescale 1ns/1ns
`include "stim_defines.svh"

module stim_source_props (
  input logic              clk,
  input logic              rst_n,
  input logic              rd_en_i,
  input logic              beat_ready_i,
  input rec_pkg::rec_tag_t rec_tag_i,
  input beat_pkg::beat_t   beat_i,
  input logic              beat_valid_i
);

  localparam int GAP_W = $clog2(`ROW_GAP + 1);

  logic             seen_rd;
  logic             last_fire;
  logic [GAP_W-1:0] gap_cnt;

  assign last_fire = beat_valid_i & beat_ready_i & beat_i.last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_rd <= 1'b0;
    end else if (rd_en_i) begin
      seen_rd <= 1'b1;
    end
  end

  // idle cycles still owed after a row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= '0;
    end else if (last_fire) begin
      gap_cnt <= GAP_W'(`ROW_GAP);
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  hold_under_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    (beat_valid_i && !beat_ready_i) |=> (beat_valid_i && $stable(beat_i)))
    else $error("beat changed or valid dropped while tready was low");

  no_tag_before_read: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_rd |-> !rec_tag_i.valid)
    else $error("record valid seen before any read strobe");

  gap_low: assert property (@(posedge clk) disable iff (!rst_n)
    (gap_cnt != '0) |-> !beat_valid_i)
    else $error("beat offered inside the row gap");

  gap_rise: assert property (@(posedge clk) disable iff (!rst_n)
    (gap_cnt == GAP_W'(1)) |=> beat_valid_i)
    else $error("beat valid did not rise after the row gap");

endmodule

bind stim_source_top stim_source_props u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .rd_en_i      (rd_en_i),
  .beat_ready_i (beat_ready_i),
  .rec_tag_i    (rec_tag_o),
  .beat_i       (beat_o),
  .beat_valid_i (beat_valid_o)
);

/* test/stim_source_tb.sv */
`timescale 1ns/1ns
`include "stim_defines.svh"

module stim_source_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 2;
  localparam int LOAD_CYCLES  = `REC_DEPTH;
  localparam int RUN_CYCLES   = 240;
  // lets the record pipeline empty out
  localparam int DRAIN_CYCLES = 8;
  localparam int READ_LIMIT   = `REC_PASSES * `REC_DEPTH;
  localparam int BEAT_W       = `BEAT_WIDTH;
  // record image followed by the frame wrap count
  localparam int GOLDEN_WORDS = `REC_DEPTH + 1;
  localparam int TOTAL_CYCLES = RESET_CYCLES + LOAD_CYCLES + RUN_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD;

  logic               clk;
  logic               rst_n;
  rec_pkg::rec_load_t load_i;
  logic               rd_en_i;
  logic               beat_ready_i;
  rec_pkg::rec_tag_t  rec_tag_o;
  rec_pkg::rec_data_t rec_data_o;
  beat_pkg::beat_t    beat_o;
  logic               beat_valid_o;

  logic [`REC_WIDTH-1:0] golden [0:GOLDEN_WORDS-1];
  logic [15:0]           lfsr_state;
  int                    rec_errors;
  int                    beat_errors;
  int                    other_errors;

  stim_source_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_i       (load_i),
    .rd_en_i      (rd_en_i),
    .beat_ready_i (beat_ready_i),
    .rec_tag_o    (rec_tag_o),
    .rec_data_o   (rec_data_o),
    .beat_o       (beat_o),
    .beat_valid_o (beat_valid_o)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic random_bit(output logic value);
    lfsr_state = lfsr_next(lfsr_state);
    value = lfsr_state[0];
  endtask

  // addr and data only matter when a record is expected
  task automatic check_rec(
    input rec_pkg::rec_tag_t  got_tag,
    input rec_pkg::rec_data_t got_data,
    input rec_pkg::rec_tag_t  exp_tag,
    input rec_pkg::rec_data_t exp_data
  );
    if (got_tag.valid !== exp_tag.valid) begin
      rec_errors++;
      $display("Error at %0t ns: record valid %b, expected %b",
               $time, got_tag.valid, exp_tag.valid);
    end else if (exp_tag.valid && (got_tag.addr !== exp_tag.addr || got_data !== exp_data)) begin
      rec_errors++;
      $display("Error at %0t ns: record addr %0d data %h, expected addr %0d data %h",
               $time, got_tag.addr, got_data, exp_tag.addr, exp_data);
    end
  endtask

  task automatic check_beat(
    input beat_pkg::beat_t got,
    input beat_pkg::beat_t exp,
    input string           what
  );
    if (got !== exp) begin
      beat_errors++;
      $display("Error at %0t ns: %s, data %0d last %b, expected data %0d last %b",
               $time, what, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      beat_errors++;
      $display("Error at %0t ns: %s, beat valid %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the test finished", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus and checking
  ////////////////////////////////////////

  initial begin
    rec_pkg::rec_tag_t  exp_tag_q [$];
    rec_pkg::rec_data_t exp_data_q [$];
    rec_pkg::rec_tag_t  exp_tag;
    rec_pkg::rec_data_t exp_data;
    beat_pkg::beat_t    exp_beat;
    beat_pkg::beat_t    prev_beat;
    logic               prev_valid;
    logic               prev_ready;
    logic               rd_bit;
    logic               ready_bit;
    logic               expect_rise;
    int                 wrap_beats;
    int                 strobes;
    int                 issued;
    int                 beats;
    int                 gap_left;

    rst_n        = 1'b0;
    load_i       = '0;
    rd_en_i      = 1'b0;
    beat_ready_i = 1'b0;
    lfsr_state   = 16'd40;
    rec_errors   = 0;
    beat_errors  = 0;
    other_errors = 0;
    strobes      = 0;
    issued       = 0;
    beats        = 0;
    gap_left     = 0;
    expect_rise  = 1'b0;
    prev_valid   = 1'b0;
    prev_ready   = 1'b0;
    prev_beat    = '0;

    $readmemh("test/stim_golden.txt", golden);
    wrap_beats = int'(golden[`REC_DEPTH]);
    if (wrap_beats <= 0) begin
      other_errors++;
      $display("golden file holds no usable frame wrap count");
      wrap_beats = 1;
    end

    // outputs seen after edge k belong to the strobe sampled at edge k-3
    for (int i = 0; i < `REC_OUT_DELAY + 1; i++) begin
      exp_tag_q.push_back('0);
      exp_data_q.push_back('0);
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    for (int cycle = 0; cycle < LOAD_CYCLES + RUN_CYCLES + DRAIN_CYCLES; cycle++) begin
      @(posedge clk);
      #(DRIVE_DELAY);

      // record expected for the strobe sampled at this edge
      exp_tag  = '0;
      exp_data = '0;
      if (rd_en_i && issued < READ_LIMIT) begin
        exp_tag.valid = 1'b1;
        exp_tag.addr  = rec_pkg::rec_addr_t'(issued % `REC_DEPTH);
        exp_data      = golden[issued % `REC_DEPTH];
        issued++;
      end
      exp_tag_q.push_back(exp_tag);
      exp_data_q.push_back(exp_data);
      check_rec(rec_tag_o, rec_data_o, exp_tag_q.pop_front(), exp_data_q.pop_front());

      if (cycle == 0) begin
        check_valid(beat_valid_o, 1'b1, "first edge after reset");
      end

      // beat accepted at this edge
      if (prev_valid && prev_ready) begin
        exp_beat.data = BEAT_W'(beats % wrap_beats);
        exp_beat.last = ((beats % `ROW_COLS) == (`ROW_COLS - 1));
        check_beat(prev_beat, exp_beat, "accepted beat");
        beats++;
        if (exp_beat.last) begin
          gap_left = `ROW_GAP;
        end else begin
          check_valid(beat_valid_o, 1'b1, "valid dropped inside a row");
        end
      end else if (prev_valid) begin
        check_valid(beat_valid_o, 1'b1, "valid dropped under back-pressure");
        check_beat(beat_o, prev_beat, "beat changed under back-pressure");
      end

      // row gap
      if (gap_left > 0) begin
        check_valid(beat_valid_o, 1'b0, "inside row gap");
        gap_left--;
        expect_rise = (gap_left == 0);
      end else if (expect_rise) begin
        check_valid(beat_valid_o, 1'b1, "end of row gap");
        expect_rise = 1'b0;
      end

      prev_valid = beat_valid_o;
      prev_beat  = beat_o;

      // next inputs
      load_i  = '0;
      rd_en_i = 1'b0;
      if (cycle < LOAD_CYCLES) begin
        load_i.en   = 1'b1;
        load_i.addr = rec_pkg::rec_addr_t'(cycle);
        load_i.data = golden[cycle];
      end else if (cycle < LOAD_CYCLES + RUN_CYCLES) begin
        random_bit(rd_bit);
        rd_en_i = rd_bit;
        if (rd_bit) begin
          strobes++;
        end
      end
      random_bit(ready_bit);
      beat_ready_i = ready_bit;
      prev_ready   = ready_bit;
    end

    if (strobes <= READ_LIMIT) begin
      other_errors++;
      $display("only %0d read strobes, the read limit was never passed", strobes);
    end
    if (beats <= wrap_beats) begin
      other_errors++;
      $display("only %0d beats accepted, no frame wrap was seen", beats);
    end

    $display("record errors %0d, beat errors %0d, other errors %0d",
             rec_errors, beat_errors, other_errors);
    if (rec_errors + beat_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
